/* rtl/qspim_cfg_pkg.sv */
package qspim_cfg_pkg;

    // --------------------------------------------------
    // SPI frame widths
    // --------------------------------------------------
    localparam int CMD_W  = 8;   // Opcode byte
    localparam int ADDR_W = 24;  // Flash address, MSB first
    localparam int DATA_W = 32;  // Host data word

    // Chip selects brought out to the pins
    localparam int NUM_CS = 4;

    // Derived widths
    localparam int BCNT_W = 2;                // Byte count field
    localparam int CSEL_W = $clog2(NUM_CS);   // Chip select index

    // --------------------------------------------------
    // Small field types
    // --------------------------------------------------

    // Data bytes in the frame minus one, 0..3
    typedef logic [BCNT_W-1:0] byte_cnt_t;

    // Index of the active low chip select
    typedef logic [CSEL_W-1:0] cs_sel_t;

    // Bit counter inside one phase, wide enough for DATA_W
    typedef logic [$clog2(DATA_W)-1:0] bit_cnt_t;

endpackage

/* rtl/qspim_bus_pkg.sv */
package qspim_bus_pkg;

    // --------------------------------------------------
    // Operation kind
    // --------------------------------------------------
    typedef enum logic {
        OP_READ  = 1'b0,   // Frame returns a response word
        OP_WRITE = 1'b1    // Posted, no response
    } spi_op_e;

    // --------------------------------------------------
    // Request, 69 bits
    // Host port -> command FIFO -> controller
    // --------------------------------------------------
    typedef struct packed {
        spi_op_e                              op;        // Read or write
        qspim_cfg_pkg::cs_sel_t               cs_sel;    // Which CS# goes low
        logic [qspim_cfg_pkg::CMD_W-1:0]      cmd;       // SPI opcode
        logic [qspim_cfg_pkg::ADDR_W-1:0]     addr;      // Flash address
        qspim_cfg_pkg::byte_cnt_t             byte_cnt;  // Data bytes minus one
        logic [qspim_cfg_pkg::DATA_W-1:0]     wdata;     // Byte 0 in [7:0] goes first
    } spi_req_t;

    // --------------------------------------------------
    // Response word
    // Byte k of the read in bits 8k+7:8k
    // Bytes beyond byte_cnt are zero
    // --------------------------------------------------
    typedef logic [qspim_cfg_pkg::DATA_W-1:0] rsp_data_t;

    // Width check value for the request
    localparam int REQ_W = $bits(spi_req_t);

endpackage

/* rtl/qspim_fifo.sv */
module qspim_fifo #(
    parameter int  DEPTH     = 2,
    parameter type payload_t = logic [31:0]
) (
    input  logic      mclk,
    input  logic      rst_n_i,

    input  logic      wr_en_i,     // Push, only when not full
    input  payload_t  wr_data_i,
    output logic      full_o,

    input  logic      rd_en_i,     // Pop, only when not empty
    output payload_t  rd_data_o,   // Head entry, valid while not empty
    output logic      empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];   // Storage
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;         // Occupancy

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge mclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en_i) begin
                // Wrap at DEPTH, depth need not be a power of two
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en_i, rd_en_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or none
            endcase
        end
    end

    // Write port
    always_ff @(posedge mclk) begin
        if (wr_en_i) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    assign rd_data_o = mem[rd_ptr];               // Head, next cycle after a write
    assign full_o    = (count == CNT_W'(DEPTH));
    assign empty_o   = (count == '0);

    // Producer and consumer must respect the flags
    a_no_wr_full: assert property (@(posedge mclk) disable iff (!rst_n_i)
        wr_en_i |-> !full_o);
    a_no_rd_empty: assert property (@(posedge mclk) disable iff (!rst_n_i)
        rd_en_i |-> !empty_o);

endmodule

/* rtl/qspim_host_if.sv */
module qspim_host_if (
    input  logic                      mclk,
    input  logic                      rst_n_i,

    // Host port, four-phase req/ack
    input  logic                      req_i,
    input  qspim_bus_pkg::spi_req_t   req_data_i,
    output logic                      ack_o,
    output qspim_bus_pkg::rsp_data_t  rdata_o,

    // Command FIFO write side
    output logic                      cmd_wr_o,
    output qspim_bus_pkg::spi_req_t   cmd_data_o,
    input  logic                      cmd_full_i,

    // Response FIFO read side
    output logic                      rsp_rd_o,
    input  qspim_bus_pkg::rsp_data_t  rsp_data_i,
    input  logic                      rsp_empty_i
);

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,   // Waiting for req_i
        ST_QUEUE = 2'd1,   // Push into command FIFO
        ST_WAIT  = 2'd2,   // Read only, wait for response word
        ST_ACK   = 2'd3    // Ack high until req_i drops
    } state_e;

    state_e state;
    state_e state_nxt;

    logic   is_write;      // Posted request, ack right after the push

    assign is_write = (req_data_i.op == qspim_bus_pkg::OP_WRITE);

    // --------------------------------------------------
    // Handshake FSM
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (req_i) state_nxt = ST_QUEUE;
            end
            ST_QUEUE: begin
                // Held here under back-pressure
                if (!cmd_full_i) begin
                    state_nxt = is_write ? ST_ACK : ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (!rsp_empty_i) state_nxt = ST_ACK;
            end
            ST_ACK: begin
                if (!req_i) state_nxt = ST_IDLE;   // Return to zero
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge mclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // One push per request, QUEUE is left on the push
    assign cmd_wr_o   = (state == ST_QUEUE) && !cmd_full_i;
    assign cmd_data_o = req_data_i;     // Host keeps it stable until ack

    // Pop on the same edge that raises ack_o
    assign rsp_rd_o   = (state == ST_WAIT) && !rsp_empty_i;

    // Read data holding register
    always_ff @(posedge mclk) begin
        if (rsp_rd_o) begin
            rdata_o <= rsp_data_i;
        end
    end

    assign ack_o = (state == ST_ACK);

    // Request payload held by the host until it sees ack
    a_req_stable: assert property (@(posedge mclk) disable iff (!rst_n_i)
        (req_i && !ack_o) ##1 (req_i && !ack_o) |-> $stable(req_data_i));

endmodule

/* rtl/qspim_ctrl.sv */
module qspim_ctrl #(
    parameter int CLK_DIV = 1          // Half period in mclk cycles, minus one
) (
    input  logic                                  mclk,
    input  logic                                  rst_n_i,

    // Command FIFO read side
    input  logic                                  cmd_empty_i,
    output logic                                  cmd_rd_o,
    input  qspim_bus_pkg::spi_req_t               cmd_data_i,

    // Response FIFO write side
    input  logic                                  rsp_full_i,
    output logic                                  rsp_wr_o,
    output qspim_bus_pkg::rsp_data_t              rsp_data_o,

    // SPI pins, mode 0
    output logic                                  spi_clk_o,
    output logic [qspim_cfg_pkg::NUM_CS-1:0]      spi_csn_o,
    output logic                                  spi_sdo_o,
    input  logic                                  spi_sdi_i
);

    localparam int DIV_W = (CLK_DIV > 0) ? $clog2(CLK_DIV + 1) : 1;
    localparam int TX_W  = qspim_cfg_pkg::CMD_W + qspim_cfg_pkg::ADDR_W
                         + qspim_cfg_pkg::DATA_W;
    localparam int BIT_W = $bits(qspim_cfg_pkg::bit_cnt_t);

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_SELECT = 3'd1,   // Half period before CS# falls
        ST_CMD    = 3'd2,
        ST_ADDR   = 3'd3,
        ST_DATA   = 3'd4,
        ST_DESEL  = 3'd5    // Half period before CS# rises
    } state_e;

    state_e                     state;
    logic [DIV_W-1:0]           div_cnt;
    logic                       tick;       // Half period boundary
    qspim_cfg_pkg::bit_cnt_t    bit_cnt;    // Bit inside the phase
    qspim_cfg_pkg::bit_cnt_t    last_bit;   // Final bit of the phase
    logic                       shifting;
    logic                       rise;       // SCK about to go high
    logic                       fall;       // SCK about to go low

    // Frame context, loaded at the pop
    logic                       op_rd_q;
    qspim_cfg_pkg::cs_sel_t     cs_q;
    qspim_cfg_pkg::byte_cnt_t   bcnt_q;
    logic [TX_W-1:0]            tx_sr;      // MSB is the bit on the line
    qspim_bus_pkg::rsp_data_t   rx_word;

    // --------------------------------------------------
    // Half period divider, held at zero while idle
    // --------------------------------------------------
    always_ff @(posedge mclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_cnt <= '0;
        end else if (state == ST_IDLE || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign tick     = (state != ST_IDLE) && (div_cnt == DIV_W'(CLK_DIV));
    assign shifting = (state == ST_CMD) || (state == ST_ADDR) || (state == ST_DATA);
    assign rise     = shifting && tick && !spi_clk_o;
    assign fall     = shifting && tick && spi_clk_o;

    // Phase lengths from the frame widths
    always_comb begin
        case (state)
            ST_CMD:  last_bit = BIT_W'(qspim_cfg_pkg::CMD_W - 1);
            ST_ADDR: last_bit = BIT_W'(qspim_cfg_pkg::ADDR_W - 1);
            default: last_bit = {bcnt_q, 3'b111};   // (byte_cnt+1)*8 - 1
        endcase
    end

    // Start a frame only with room for a response
    assign cmd_rd_o = (state == ST_IDLE) && !cmd_empty_i && !rsp_full_i;

    // --------------------------------------------------
    // Phase FSM and pin registers
    // --------------------------------------------------
    always_ff @(posedge mclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= ST_IDLE;
            bit_cnt   <= '0;
            spi_clk_o <= 1'b0;
            spi_csn_o <= '1;
            spi_sdo_o <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_rd_o) state <= ST_SELECT;
                end
                ST_SELECT: begin
                    if (tick) begin
                        spi_csn_o <= ~(qspim_cfg_pkg::NUM_CS'(1) << cs_q);
                        spi_sdo_o <= tx_sr[TX_W-1];   // First cmd bit set up
                        bit_cnt   <= '0;
                        state     <= ST_CMD;
                    end
                end
                ST_CMD, ST_ADDR, ST_DATA: begin
                    if (tick) spi_clk_o <= ~spi_clk_o;
                    if (fall) begin
                        spi_sdo_o <= tx_sr[TX_W-2];   // Next bit after the shift
                        if (bit_cnt == last_bit) begin
                            bit_cnt <= '0;
                            case (state)
                                ST_CMD:  state <= ST_ADDR;
                                ST_ADDR: state <= ST_DATA;
                                default: begin
                                    state     <= ST_DESEL;
                                    spi_sdo_o <= 1'b0;
                                end
                            endcase
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                ST_DESEL: begin
                    if (tick) begin
                        spi_csn_o <= '1;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // Shift data path
    // --------------------------------------------------
    always_ff @(posedge mclk) begin
        if (cmd_rd_o) begin
            op_rd_q <= (cmd_data_i.op == qspim_bus_pkg::OP_READ);
            cs_q    <= cmd_data_i.cs_sel;
            bcnt_q  <= cmd_data_i.byte_cnt;
            rx_word <= '0;    // Unread bytes stay zero
            // Data bytes go out byte 0 first, sdo low on reads
            if (cmd_data_i.op == qspim_bus_pkg::OP_WRITE) begin
                tx_sr <= {cmd_data_i.cmd, cmd_data_i.addr,
                          cmd_data_i.wdata[7:0],   cmd_data_i.wdata[15:8],
                          cmd_data_i.wdata[23:16], cmd_data_i.wdata[31:24]};
            end else begin
                tx_sr <= {cmd_data_i.cmd, cmd_data_i.addr,
                          {qspim_cfg_pkg::DATA_W{1'b0}}};
            end
        end else begin
            if (fall) tx_sr <= {tx_sr[TX_W-2:0], 1'b0};
            // Byte k in 8k+7:8k, MSB of each byte first
            if (rise && state == ST_DATA && op_rd_q) begin
                rx_word[{bit_cnt[4:3], ~bit_cnt[2:0]}] <= spi_sdi_i;
            end
        end
    end

    // Response pushed as CS# rises
    assign rsp_wr_o   = (state == ST_DESEL) && tick && op_rd_q;
    assign rsp_data_o = rx_word;

    a_cs_onehot: assert property (@(posedge mclk) disable iff (!rst_n_i)
        $onehot0(~spi_csn_o));
    // SCK only toggles inside a frame, never across a CS# edge
    a_clk_in_frame: assert property (@(posedge mclk) disable iff (!rst_n_i)
        spi_clk_o |=> (!(&spi_csn_o) && $stable(spi_csn_o)));

endmodule

/* rtl/qspim_top.sv */
module qspim_top #(
    parameter int CLK_DIV   = 1,   // SPI half period minus one
    parameter int CMD_DEPTH = 2,
    parameter int RSP_DEPTH = 2
) (
    input  logic                              mclk,
    input  logic                              rst_n_i,

    // Host port
    input  logic                              req_i,
    input  qspim_bus_pkg::spi_req_t           req_data_i,
    output logic                              ack_o,
    output qspim_bus_pkg::rsp_data_t          rdata_o,

    // SPI pins
    output logic                              spi_clk_o,
    output logic [qspim_cfg_pkg::NUM_CS-1:0]  spi_csn_o,
    output logic                              spi_sdo_o,
    input  logic                              spi_sdi_i
);

    // --------------------------------------------------
    // Command path
    // --------------------------------------------------
    logic                       cmd_wr;
    logic                       cmd_rd;
    logic                       cmd_full;
    logic                       cmd_empty;
    qspim_bus_pkg::spi_req_t    cmd_wdata;
    qspim_bus_pkg::spi_req_t    cmd_rdata;   // FIFO head

    // --------------------------------------------------
    // Response path
    // --------------------------------------------------
    logic                       rsp_wr;
    logic                       rsp_rd;
    logic                       rsp_full;
    logic                       rsp_empty;
    qspim_bus_pkg::rsp_data_t   rsp_wdata;
    qspim_bus_pkg::rsp_data_t   rsp_rdata;

    qspim_host_if u_host_if (
        .mclk        (mclk        ),
        .rst_n_i     (rst_n_i     ),
        .req_i       (req_i       ),
        .req_data_i  (req_data_i  ),
        .ack_o       (ack_o       ),
        .rdata_o     (rdata_o     ),
        .cmd_wr_o    (cmd_wr      ),   // Push request
        .cmd_data_o  (cmd_wdata   ),
        .cmd_full_i  (cmd_full    ),
        .rsp_rd_o    (rsp_rd      ),   // Pop response with ack
        .rsp_data_i  (rsp_rdata   ),
        .rsp_empty_i (rsp_empty   )
    );

    // Request queue, posted writes pile up here
    qspim_fifo #(.DEPTH(CMD_DEPTH), .payload_t(qspim_bus_pkg::spi_req_t)) u_cmd_fifo (
        .mclk        (mclk        ),
        .rst_n_i     (rst_n_i     ),
        .wr_en_i     (cmd_wr      ),
        .wr_data_i   (cmd_wdata   ),
        .full_o      (cmd_full    ),
        .rd_en_i     (cmd_rd      ),
        .rd_data_o   (cmd_rdata   ),
        .empty_o     (cmd_empty   )
    );

    // Read words back to the host
    qspim_fifo #(.DEPTH(RSP_DEPTH), .payload_t(qspim_bus_pkg::rsp_data_t)) u_rsp_fifo (
        .mclk        (mclk        ),
        .rst_n_i     (rst_n_i     ),
        .wr_en_i     (rsp_wr      ),
        .wr_data_i   (rsp_wdata   ),
        .full_o      (rsp_full    ),
        .rd_en_i     (rsp_rd      ),
        .rd_data_o   (rsp_rdata   ),
        .empty_o     (rsp_empty   )
    );

    qspim_ctrl #(.CLK_DIV(CLK_DIV)) u_ctrl (
        .mclk        (mclk        ),
        .rst_n_i     (rst_n_i     ),
        .cmd_empty_i (cmd_empty   ),
        .cmd_rd_o    (cmd_rd      ),
        .cmd_data_i  (cmd_rdata   ),
        .rsp_full_i  (rsp_full    ),   // Stalls the next frame
        .rsp_wr_o    (rsp_wr      ),
        .rsp_data_o  (rsp_wdata   ),
        .spi_clk_o   (spi_clk_o   ),
        .spi_csn_o   (spi_csn_o   ),
        .spi_sdo_o   (spi_sdo_o   ),
        .spi_sdi_i   (spi_sdi_i   )
    );

endmodule

/* verif/qspim_flash_model.sv */
module qspim_flash_model #(
    parameter logic [7:0] RD_OP = 8'h03,   // Read data opcode
    parameter logic [7:0] WR_OP = 8'h02    // Program opcode
) (
    input  logic                              spi_clk_i,
    input  logic [qspim_cfg_pkg::NUM_CS-1:0]  spi_csn_i,
    input  logic                              spi_sdo_i,   // Master out
    output logic                              spi_sdi_o    // Master in
);

    logic [7:0]   mem [256];
    bit           loaded = 1'b0;    // Preset done
    logic [7:0]   cmd;
    logic [23:0]  addr;
    logic [7:0]   dbyte;
    logic [7:0]   idx;
    int           nbits = 0;        // Bits seen in this frame
    logic         sdi_q = 1'b0;
    logic         cs_idle;

    assign cs_idle   = &spi_csn_i;   // Any select low opens a frame
    assign spi_sdi_o = sdi_q;

    // --------------------------------------------------
    // Capture on rising SCK, frame ends with CS# high
    // --------------------------------------------------
    always @(posedge spi_clk_i or posedge cs_idle) begin
        if (!loaded) begin
            for (int i = 0; i < 256; i++) mem[i] = 8'(i);   // Byte equals its address
            loaded = 1'b1;
        end
        if (cs_idle) begin
            nbits = 0;
        end else begin
            if (nbits < 8) begin
                cmd = {cmd[6:0], spi_sdo_i};
            end else if (nbits < 32) begin
                addr = {addr[22:0], spi_sdo_i};
            end else begin
                dbyte = {dbyte[6:0], spi_sdo_i};
                // Full byte in, store at addr + k
                if ((nbits % 8) == 7 && cmd == WR_OP) begin
                    idx      = addr[7:0] + 8'((nbits - 32) / 8);
                    mem[idx] = dbyte;
                end
            end
            nbits++;
        end
    end

    // Read data shifted out on falling SCK, MSB first
    always @(negedge spi_clk_i) begin
        if (!cs_idle && nbits >= 32 && cmd == RD_OP) begin
            sdi_q <= mem[addr[7:0] + 8'((nbits - 32) / 8)][7 - (nbits % 8)];
        end else begin
            sdi_q <= 1'b0;
        end
    end

endmodule

/* verif/qspim_checker.sv */
module qspim_checker (
    input  logic                              mclk,
    input  logic                              rst_n_i,
    input  logic                              req_i,
    input  qspim_bus_pkg::spi_req_t           req_data_i,
    input  logic                              ack_i,
    input  qspim_bus_pkg::rsp_data_t          rdata_i,
    input  logic                              spi_clk_i,
    input  logic [qspim_cfg_pkg::NUM_CS-1:0]  spi_csn_i,
    input  logic                              spi_sdo_i,
    output int                                errors_o,
    output int                                pending_o   // Requests with no frame yet
);

    logic [7:0]                         arr [256];   // Expected flash contents
    qspim_bus_pkg::spi_req_t            exp_q [$];   // Frames to come in request order
    qspim_bus_pkg::rsp_data_t           rd_word;     // Expected rdata_o
    logic                               rd_open;     // Read waiting for its ack
    logic                               started;
    logic                               req_q;
    logic                               ack_q;
    logic                               clk_q;
    logic [qspim_cfg_pkg::NUM_CS-1:0]   csn_q;
    logic [qspim_cfg_pkg::NUM_CS-1:0]   cs_frame;    // Select seen at frame start
    logic [63:0]                        sh;          // Bits off sdo
    int                                 nbits;
    int                                 errors = 0;
    int                                 pending = 0;

    assign errors_o  = errors;
    assign pending_o = pending;

    function automatic void check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            errors++;
        end
    endfunction

    // --------------------------------------------------
    // Host side model
    // --------------------------------------------------
    task automatic capture_request(input qspim_bus_pkg::spi_req_t r);
        logic [7:0] a;
        a = r.addr[7:0];
        exp_q.push_back(r);
        if (r.op == qspim_bus_pkg::OP_WRITE) begin
            for (int k = 0; k <= int'(r.byte_cnt); k++) begin
                arr[a + 8'(k)] = r.wdata[8*k +: 8];
            end
        end else begin
            rd_word = '0;    // Bytes past byte_cnt read back as zero
            for (int k = 0; k <= int'(r.byte_cnt); k++) begin
                rd_word[8*k +: 8] = arr[a + 8'(k)];
            end
            rd_open = 1'b1;
        end
    endtask

    // Closed frame against the oldest request
    task automatic check_frame();
        qspim_bus_pkg::spi_req_t            r;
        logic [qspim_cfg_pkg::NUM_CS-1:0]   cs_exp;
        int                                 nexp;
        if (exp_q.size() == 0) begin
            $display("SPI frame on the pins with no request pending at %0t", $time);
            errors++;
            return;
        end
        r = exp_q.pop_front();
        for (int i = 0; i < qspim_cfg_pkg::NUM_CS; i++) begin
            cs_exp[i] = (i != int'(r.cs_sel));   // Only the selected CS# low
        end
        nexp = 32 + 8 * (int'(r.byte_cnt) + 1);
        check_value("spi_csn_o", 32'(cs_frame), 32'(cs_exp));
        check_value("spi_clk_o rising edges", nbits, nexp);
        if (nbits == nexp) begin
            check_value("spi_sdo_o cmd", 32'(sh[nbits-1 -: 8]), 32'(r.cmd));
            check_value("spi_sdo_o addr", 32'(sh[nbits-9 -: 24]), 32'(r.addr));
            if (r.op == qspim_bus_pkg::OP_WRITE) begin
                for (int k = 0; k <= int'(r.byte_cnt); k++) begin
                    check_value($sformatf("spi_sdo_o data byte %0d", k),
                                32'(sh[nbits-33-8*k -: 8]), 32'(r.wdata[8*k +: 8]));
                end
            end
        end
    endtask

    // --------------------------------------------------
    // Sampled on mclk with the values from before the edge
    // --------------------------------------------------
    always @(posedge mclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 256; i++) arr[i] = 8'(i);   // Same preset as the flash
            exp_q.delete();
            rd_word  = '0;
            rd_open  = 1'b0;
            started  = 1'b0;
            req_q    = 1'b0;
            ack_q    = 1'b0;
            clk_q    = 1'b0;
            csn_q    = '1;
            cs_frame = '1;
            sh       = '0;
            nbits    = 0;
        end else begin
            // Pins quiet until the first request
            if (!started && !req_i) begin
                check_value("ack_o", 32'(ack_i), 32'h0);
                check_value("spi_csn_o", 32'(spi_csn_i),
                            32'({qspim_cfg_pkg::NUM_CS{1'b1}}));
                check_value("spi_clk_o", 32'(spi_clk_i), 32'h0);
                check_value("spi_sdo_o", 32'(spi_sdo_i), 32'h0);
            end
            if (req_i && !req_q) begin
                started = 1'b1;
                capture_request(req_data_i);
            end
            if (ack_i && !ack_q && rd_open) begin
                check_value("rdata_o", rdata_i, rd_word);
                rd_open = 1'b0;
            end
            if (!(&spi_csn_i) && (&csn_q)) begin   // Frame opens
                sh       = '0;
                nbits    = 0;
                cs_frame = spi_csn_i;
            end
            if (!(&spi_csn_i)) begin
                if (spi_csn_i != cs_frame) begin
                    check_value("spi_csn_o mid-frame", 32'(spi_csn_i), 32'(cs_frame));
                    cs_frame = spi_csn_i;
                end
                if (spi_clk_i && !clk_q) begin     // Rising SCK
                    sh = {sh[62:0], spi_sdo_i};
                    nbits++;
                end
            end
            if ((&spi_csn_i) && !(&csn_q)) begin
                check_frame();
                cs_frame = '1;
            end
            req_q   = req_i;
            ack_q   = ack_i;
            clk_q   = spi_clk_i;
            csn_q   = spi_csn_i;
            pending = exp_q.size();
        end
    end

endmodule

/* verif/tb_qspim.sv */
module tb_qspim;

    localparam int          CLK_DIV   = 1;
    localparam int          CMD_DEPTH = 2;
    localparam int          RSP_DEPTH = 2;
    localparam logic [7:0]  RD_OP     = 8'h03;
    localparam logic [7:0]  WR_OP     = 8'h02;
    localparam logic [15:0] ADDR_HI   = 16'h0010;   // Fixed upper address bytes
    localparam int          NUM_REQ   = 60;
    localparam int          BURST     = 6;          // Leading writes, fill the command FIFO
    localparam int          WAIT_MAX  = 4000;       // mclk cycles per wait

    logic                               mclk = 1'b0;
    logic                               rst_n;
    logic                               req;
    qspim_bus_pkg::spi_req_t            req_data;
    logic                               ack;
    qspim_bus_pkg::rsp_data_t           rdata;
    logic                               spi_clk;
    logic [qspim_cfg_pkg::NUM_CS-1:0]   spi_csn;
    logic                               spi_sdo;
    logic                               spi_sdi;

    integer                             seed;
    int                                 timeouts;
    int                                 done_cnt;
    int                                 chk_errors;
    int                                 chk_pending;

    always #10 mclk = ~mclk;    // 20 unit period

    qspim_top #(
        .CLK_DIV   (CLK_DIV  ),
        .CMD_DEPTH (CMD_DEPTH),
        .RSP_DEPTH (RSP_DEPTH)
    ) u_qspim_top (
        .mclk       (mclk    ),
        .rst_n_i    (rst_n   ),
        .req_i      (req     ),
        .req_data_i (req_data),
        .ack_o      (ack     ),
        .rdata_o    (rdata   ),
        .spi_clk_o  (spi_clk ),
        .spi_csn_o  (spi_csn ),
        .spi_sdo_o  (spi_sdo ),
        .spi_sdi_i  (spi_sdi )
    );

    qspim_flash_model #(.RD_OP(RD_OP), .WR_OP(WR_OP)) u_flash (
        .spi_clk_i  (spi_clk ),
        .spi_csn_i  (spi_csn ),
        .spi_sdo_i  (spi_sdo ),
        .spi_sdi_o  (spi_sdi )
    );

    qspim_checker u_checker (
        .mclk       (mclk       ),
        .rst_n_i    (rst_n      ),
        .req_i      (req        ),
        .req_data_i (req_data   ),
        .ack_i      (ack        ),
        .rdata_i    (rdata      ),
        .spi_clk_i  (spi_clk    ),
        .spi_csn_i  (spi_csn    ),
        .spi_sdo_i  (spi_sdo    ),
        .errors_o   (chk_errors ),
        .pending_o  (chk_pending)
    );

    // --------------------------------------------------
    // Handshake helpers, sampled 2 units after the edge
    // --------------------------------------------------
    task automatic wait_ack(input logic level, output bit ok);
        int n;
        n = 0;
        while (ack !== level && n < WAIT_MAX) begin
            @(posedge mclk);
            #2;
            n++;
        end
        ok = (ack === level);
    endtask

    task automatic run_request(input int idx, input bit force_write);
        logic [31:0]             rnd;
        qspim_bus_pkg::spi_req_t r;
        bit                      ok;
        rnd        = $random(seed);
        r.op       = (force_write || rnd[0]) ? qspim_bus_pkg::OP_WRITE : qspim_bus_pkg::OP_READ;
        r.cs_sel   = rnd[2:1];
        r.byte_cnt = rnd[4:3];
        r.cmd      = (r.op == qspim_bus_pkg::OP_WRITE) ? WR_OP : RD_OP;
        r.addr     = {ADDR_HI, rnd[12:5]};
        r.wdata    = $random(seed);
        @(posedge mclk);
        #2;
        req_data = r;
        req      = 1'b1;
        wait_ack(1'b1, ok);
        if (ok) begin
            req = 1'b0;    // Return to zero
            wait_ack(1'b0, ok);
        end
        if (ok) begin
            done_cnt++;
        end else begin
            timeouts++;
            $display("Timeout in the ack_o handshake of request %0d", idx);
        end
    endtask

    // Posted writes may still be on the line
    task automatic wait_drain();
        int n;
        n = 0;
        while ((chk_pending != 0 || spi_csn != '1) && n < WAIT_MAX) begin
            @(posedge mclk);
            #2;
            n++;
        end
        if (chk_pending != 0 || spi_csn != '1) begin
            timeouts++;
            $display("Timeout with %0d SPI frames still missing", chk_pending);
        end
    endtask

    task automatic finish_run();
        $display("requests: %0d  errors: %0d  timeouts: %0d", done_cnt, chk_errors, timeouts);
        if (chk_errors == 0 && timeouts == 0 && done_cnt == NUM_REQ) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    initial begin
        seed     = 84;
        timeouts = 0;
        done_cnt = 0;
        rst_n    = 1'b0;
        req      = 1'b0;
        req_data = '0;
        repeat (5) @(posedge mclk);
        #2 rst_n = 1'b1;
        repeat (4) @(posedge mclk);    // Idle pins watched here
        for (int i = 0; i < NUM_REQ; i++) begin
            if (timeouts == 0) run_request(i, i < BURST);
        end
        if (timeouts == 0) wait_drain();
        finish_run();
    end

endmodule

/* build.f */
rtl/qspim_cfg_pkg.sv
rtl/qspim_bus_pkg.sv
rtl/qspim_fifo.sv
rtl/qspim_host_if.sv
rtl/qspim_ctrl.sv
rtl/qspim_top.sv
verif/qspim_flash_model.sv
verif/qspim_checker.sv
verif/tb_qspim.sv

/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        ?= tb_qspim
RTL_TOP    ?= qspim_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

# Lint the synthesizable hierarchy only
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# Build and run, fail unless the pass line shows up
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)
